/* rtl/soc_pkg.sv */
// Shared definitions for the Wishbone peripheral slice
// Bus widths, peripheral address map, register indices and timer control bits

package soc_pkg;

	//----------------------------------------------------------------------
	// Bus widths
	//----------------------------------------------------------------------
	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;

	//----------------------------------------------------------------------
	// Address map
	//----------------------------------------------------------------------
	// Upper address bits pick the peripheral region
	localparam int REGION_MSB = 31;
	localparam int REGION_LSB = 17;
	localparam logic [REGION_MSB-REGION_LSB:0] TIMER_REGION = 15'h7001;
	localparam logic [REGION_MSB-REGION_LSB:0] GPIO_REGION  = 15'h7002;

	// Word-addressed register index inside a region
	localparam int REG_LSB = 2;
	localparam int REG_MSB = 4;

	// Default width of the LED / switch port
	localparam int GPIO_W_DEFAULT = 8;

	// Slave selected by the current cycle
	typedef enum logic [1:0] {
		TGT_NONE  = 2'd0,
		TGT_TIMER = 2'd1,
		TGT_GPIO  = 2'd2
	} target_e;

	// GPIO register indices
	typedef enum logic [REG_MSB-REG_LSB:0] {
		GPIO_IN   = 3'd0,
		GPIO_OUT  = 3'd1,
		GPIO_MASK = 3'd2
	} gpio_reg_e;

	// Timer register indices, bit 2 picks the channel
	typedef enum logic [REG_MSB-REG_LSB:0] {
		T0_CTRL    = 3'd0,
		T0_COMPARE = 3'd1,
		T0_COUNTER = 3'd2,
		T1_CTRL    = 3'd4,
		T1_COMPARE = 3'd5,
		T1_COUNTER = 3'd6
	} timer_reg_e;

	// Timer control register bits
	localparam int TCTRL_EN    = 0;
	localparam int TCTRL_AR    = 1;
	localparam int TCTRL_IRQEN = 2;
	localparam int TCTRL_TRIG  = 3;

endpackage

/* rtl/wb_gpio.sv */
// GPIO slave on the peripheral bus
// Drives the LED outputs, samples the switches and raises a masked
// level interrupt from the sampled inputs

`timescale 1ns/100ps

module wb_gpio #(
	parameter int gpio_w = 8
) (
	input  logic                      clk,
	input  logic                      reset_i,
	input  logic                      stb_i,
	input  logic                      we_i,
	input  soc_pkg::gpio_reg_e        reg_i,
	input  logic [soc_pkg::DATA_W-1:0] dat_i,
	input  logic [gpio_w-1:0]         gpio_in_i,
	output logic [soc_pkg::DATA_W-1:0] dat_o,
	output logic                      ack_o,
	output logic [gpio_w-1:0]         gpio_out_o,
	output logic                      irq_o
);

	// Sampled switches, LED value and interrupt mask
	logic [gpio_w-1:0] in_r;
	logic [gpio_w-1:0] out_r;
	logic [gpio_w-1:0] mask_r;
	logic              req;
	logic [gpio_w-1:0] rd_val;

	// First cycle of a request only, the ack cycle is ignored
	assign req = stb_i && !ack_o;

	//----------------------------------------------------------------------
	// Read mux
	//----------------------------------------------------------------------
	always_comb begin
		case (reg_i)
			soc_pkg::GPIO_IN:   rd_val = in_r;
			soc_pkg::GPIO_OUT:  rd_val = out_r;
			soc_pkg::GPIO_MASK: rd_val = mask_r;
			default:            rd_val = '0;
		endcase
	end

	//----------------------------------------------------------------------
	// Control registers, ack and interrupt
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset_i) begin
			ack_o  <= 1'b0;
			out_r  <= '0;
			mask_r <= '0;
			irq_o  <= 1'b0;
		end else begin
			// One ack per request, one cycle after the strobe
			ack_o <= req;
			if (req && we_i) begin
				// GPIO_IN is read only, a write there falls through
				if (reg_i == soc_pkg::GPIO_OUT)
					out_r <= dat_i[gpio_w-1:0];
				if (reg_i == soc_pkg::GPIO_MASK)
					mask_r <= dat_i[gpio_w-1:0];
			end
			// Level request from any unmasked input
			irq_o <= |(in_r & mask_r);
		end
	end

	// Input sampling and read data, zero when not answering
	always_ff @(posedge clk) begin
		in_r  <= gpio_in_i;
		dat_o <= req ? {{(soc_pkg::DATA_W-gpio_w){1'b0}}, rd_val} : '0;
	end

	assign gpio_out_o = out_r;

endmodule

/* rtl/wb_timer.sv */
// Two-channel timer slave on the peripheral bus
// Each channel counts up to its compare value, then sets a sticky trigger,
// restarts from zero and stops unless auto-reload is set

`timescale 1ns/100ps

module wb_timer (
	input  logic                       clk,
	input  logic                       reset_i,
	input  logic                       stb_i,
	input  logic                       we_i,
	input  soc_pkg::timer_reg_e        reg_i,
	input  logic [soc_pkg::DATA_W-1:0] dat_i,
	output logic [soc_pkg::DATA_W-1:0] dat_o,
	output logic                       ack_o,
	output logic [1:0]                 irq_o
);

	localparam int N_CH = 2;

	// Per channel state, index 0 is timer 0
	logic [N_CH-1:0][3:0]                ctrl_r;
	logic [N_CH-1:0][soc_pkg::DATA_W-1:0] cmp_r;
	logic [N_CH-1:0][soc_pkg::DATA_W-1:0] cnt_r;

	// Write strobes and compare hits
	logic [N_CH-1:0] wr_ctrl;
	logic [N_CH-1:0] wr_cmp;
	logic [N_CH-1:0] wr_cnt;
	logic [N_CH-1:0] match;
	logic            req;
	logic [soc_pkg::DATA_W-1:0] rd_val;

	assign req = stb_i && !ack_o;

	//----------------------------------------------------------------------
	// Register decode
	//----------------------------------------------------------------------
	always_comb begin
		wr_ctrl = '0;
		wr_cmp  = '0;
		wr_cnt  = '0;
		rd_val  = '0;
		case (reg_i)
			soc_pkg::T0_CTRL: begin
				wr_ctrl[0] = req && we_i;
				rd_val     = {{(soc_pkg::DATA_W-4){1'b0}}, ctrl_r[0]};
			end
			soc_pkg::T0_COMPARE: begin
				wr_cmp[0] = req && we_i;
				rd_val    = cmp_r[0];
			end
			soc_pkg::T0_COUNTER: begin
				wr_cnt[0] = req && we_i;
				rd_val    = cnt_r[0];
			end
			soc_pkg::T1_CTRL: begin
				wr_ctrl[1] = req && we_i;
				rd_val     = {{(soc_pkg::DATA_W-4){1'b0}}, ctrl_r[1]};
			end
			soc_pkg::T1_COMPARE: begin
				wr_cmp[1] = req && we_i;
				rd_val    = cmp_r[1];
			end
			soc_pkg::T1_COUNTER: begin
				wr_cnt[1] = req && we_i;
				rd_val    = cnt_r[1];
			end
			// Unlisted indices read zero
			default: rd_val = '0;
		endcase
	end

	// Compare only counts while the channel is running
	always_comb begin
		for (int c = 0; c < N_CH; c++) begin
			match[c] = ctrl_r[c][soc_pkg::TCTRL_EN] && (cnt_r[c] == cmp_r[c]);
		end
	end

	//----------------------------------------------------------------------
	// Counters and control
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset_i) begin
			ack_o  <= 1'b0;
			ctrl_r <= '0;
			cmp_r  <= '0;
			cnt_r  <= '0;
		end else begin
			ack_o <= req;
			for (int c = 0; c < N_CH; c++) begin
				// Bus write takes all four bits, so TRIG clears here
				if (wr_ctrl[c]) begin
					ctrl_r[c] <= dat_i[3:0];
				end else if (match[c]) begin
					ctrl_r[c][soc_pkg::TCTRL_TRIG] <= 1'b1;
					if (!ctrl_r[c][soc_pkg::TCTRL_AR])
						ctrl_r[c][soc_pkg::TCTRL_EN] <= 1'b0;
				end
				if (wr_cmp[c])
					cmp_r[c] <= dat_i;
				// Load from bus, restart on a hit, else step
				if (wr_cnt[c])
					cnt_r[c] <= dat_i;
				else if (match[c])
					cnt_r[c] <= '0;
				else if (ctrl_r[c][soc_pkg::TCTRL_EN])
					cnt_r[c] <= cnt_r[c] + 1'b1;
			end
		end
	end

	// Read data only in the ack cycle, zero otherwise for the OR merge
	always_ff @(posedge clk) begin
		dat_o <= req ? rd_val : '0;
	end

	// Level request per channel
	assign irq_o[0] = ctrl_r[0][soc_pkg::TCTRL_TRIG] && ctrl_r[0][soc_pkg::TCTRL_IRQEN];
	assign irq_o[1] = ctrl_r[1][soc_pkg::TCTRL_TRIG] && ctrl_r[1][soc_pkg::TCTRL_IRQEN];

endmodule

/* rtl/wb_periph_decode.sv */
// Peripheral address decoder
// Routes the bus strobe to the timer or GPIO slave, merges their acks and
// read data, answers unmapped cycles and builds the active-low IRQ vector

`timescale 1ns/100ps

module wb_periph_decode (
	input  logic                                   clk,
	input  logic                                   reset_i,
	input  logic                                   cyc_i,
	input  logic                                   stb_i,
	input  logic [soc_pkg::ADDR_W-1:0]             adr_i,
	input  logic [soc_pkg::DATA_W-1:0]             timer_dat_i,
	input  logic                                   timer_ack_i,
	input  logic [1:0]                             timer_irq_i,
	input  logic [soc_pkg::DATA_W-1:0]             gpio_dat_i,
	input  logic                                   gpio_ack_i,
	input  logic                                   gpio_irq_i,
	output logic                                   timer_stb_o,
	output logic                                   gpio_stb_o,
	output logic [soc_pkg::REG_MSB-soc_pkg::REG_LSB:0] reg_o,
	output logic [soc_pkg::DATA_W-1:0]             dat_o,
	output logic                                   ack_o,
	output logic [2:0]                             irq_n_o
);

	soc_pkg::target_e tgt;
	logic [soc_pkg::REGION_MSB-soc_pkg::REGION_LSB:0] region;
	logic             bus_req;
	logic             none_ack_r;

	//----------------------------------------------------------------------
	// Region compare
	//----------------------------------------------------------------------
	assign region  = adr_i[soc_pkg::REGION_MSB:soc_pkg::REGION_LSB];
	assign bus_req = cyc_i && stb_i;

	always_comb begin
		if (region == soc_pkg::TIMER_REGION)
			tgt = soc_pkg::TGT_TIMER;
		else if (region == soc_pkg::GPIO_REGION)
			tgt = soc_pkg::TGT_GPIO;
		else
			tgt = soc_pkg::TGT_NONE;
	end

	// Strobe goes to exactly one slave
	assign timer_stb_o = bus_req && (tgt == soc_pkg::TGT_TIMER);
	assign gpio_stb_o  = bus_req && (tgt == soc_pkg::TGT_GPIO);

	// Word index within the region
	assign reg_o = adr_i[soc_pkg::REG_MSB:soc_pkg::REG_LSB];

	//----------------------------------------------------------------------
	// Unmapped cycles
	//----------------------------------------------------------------------
	// Ack one cycle late, held off while the same stb is still up
	always_ff @(posedge clk) begin
		if (reset_i)
			none_ack_r <= 1'b0;
		else
			none_ack_r <= bus_req && (tgt == soc_pkg::TGT_NONE) && !none_ack_r;
	end

	// Only one source answers at a time, idle slaves return zero
	assign ack_o = timer_ack_i | gpio_ack_i | none_ack_r;
	assign dat_o = timer_dat_i | gpio_dat_i;

	//----------------------------------------------------------------------
	// Interrupt vector
	//----------------------------------------------------------------------
	// Bit 0 timer 0, bit 1 GPIO, bit 2 timer 1
	assign irq_n_o = ~{timer_irq_i[1], gpio_irq_i, timer_irq_i[0]};

endmodule

/* rtl/soc_periph_top.sv */
// Peripheral slice top level
// Wishbone decoder with the GPIO and timer slaves side by side

`timescale 1ns/100ps

module soc_periph_top #(
	parameter int gpio_w = soc_pkg::GPIO_W_DEFAULT
) (
	input  logic                       clk,
	input  logic                       reset_i,
	// Bus from the master
	input  logic                       cyc_i,
	input  logic                       stb_i,
	input  logic                       we_i,
	input  logic [soc_pkg::ADDR_W-1:0] adr_i,
	input  logic [soc_pkg::DATA_W-1:0] dat_i,
	output logic [soc_pkg::DATA_W-1:0] dat_o,
	output logic                       ack_o,
	// Switches, LEDs and interrupts
	input  logic [gpio_w-1:0]          gpio_in_i,
	output logic [gpio_w-1:0]          gpio_out_o,
	output logic [2:0]                 irq_n_o
);

	//----------------------------------------------------------------------
	// Slave side wires
	//----------------------------------------------------------------------
	logic                                   timer_stb;
	logic                                   gpio_stb;
	logic [soc_pkg::REG_MSB-soc_pkg::REG_LSB:0] reg_idx;
	logic [soc_pkg::DATA_W-1:0]             timer_dat;
	logic [soc_pkg::DATA_W-1:0]             gpio_dat;
	logic                                   timer_ack;
	logic                                   gpio_ack;
	logic [1:0]                             timer_irq;
	logic                                   gpio_irq;

	wb_periph_decode decode_inst (
		.clk         (clk),
		.reset_i     (reset_i),
		.cyc_i       (cyc_i),
		.stb_i       (stb_i),
		.adr_i       (adr_i),
		.timer_dat_i (timer_dat),
		.timer_ack_i (timer_ack),
		.timer_irq_i (timer_irq),
		.gpio_dat_i  (gpio_dat),
		.gpio_ack_i  (gpio_ack),
		.gpio_irq_i  (gpio_irq),
		.timer_stb_o (timer_stb),
		.gpio_stb_o  (gpio_stb),
		.reg_o       (reg_idx),
		.dat_o       (dat_o),
		.ack_o       (ack_o),
		.irq_n_o     (irq_n_o)
	);

	// LEDs and switches
	wb_gpio #(
		.gpio_w (gpio_w)
	) gpio_inst (
		.clk        (clk),
		.reset_i    (reset_i),
		.stb_i      (gpio_stb),
		.we_i       (we_i),
		.reg_i      (soc_pkg::gpio_reg_e'(reg_idx)),
		.dat_i      (dat_i),
		.gpio_in_i  (gpio_in_i),
		.dat_o      (gpio_dat),
		.ack_o      (gpio_ack),
		.gpio_out_o (gpio_out_o),
		.irq_o      (gpio_irq)
	);

	// Two timers
	wb_timer timer_inst (
		.clk     (clk),
		.reset_i (reset_i),
		.stb_i   (timer_stb),
		.we_i    (we_i),
		.reg_i   (soc_pkg::timer_reg_e'(reg_idx)),
		.dat_i   (dat_i),
		.dat_o   (timer_dat),
		.ack_o   (timer_ack),
		.irq_o   (timer_irq)
	);

endmodule

/* sim/soc_periph_properties.sv */
// Bus and interrupt properties for the peripheral slice
// Bound into the top level, single-cycle ack and idle IRQ vector out of reset

`timescale 1ns/100ps

module soc_periph_properties (
	input logic       clk,
	input logic       reset_i,
	input logic       stb_i,
	input logic       ack_o,
	input logic [2:0] irq_n_o
);

	// Ack only inside a strobe
	ack_in_stb: assert property (@(posedge clk) disable iff (reset_i) ack_o |-> stb_i)
		else $error("ack_o high while stb_i is low");

	// One ack per request, never two cycles in a row
	ack_single: assert property (@(posedge clk) disable iff (reset_i) ack_o |=> !ack_o)
		else $error("ack_o high for two consecutive cycles");

	// All requests idle once reset has been seen
	irq_idle_reset: assert property (@(posedge clk) reset_i |=> (irq_n_o == 3'b111))
		else $error("irq_n_o not all ones after reset");

endmodule

bind soc_periph_top soc_periph_properties props_inst (
	.clk     (clk),
	.reset_i (reset_i),
	.stb_i   (stb_i),
	.ack_o   (ack_o),
	.irq_n_o (irq_n_o)
);

/* sim/soc_periph_tb.sv */
// Testbench for the Wishbone peripheral slice
// Acts as the only bus master, drives LFSR data and checks the GPIO,
// timer and unmapped responses against a register model

`timescale 1ns/100ps

module soc_periph_tb;

	localparam int DW = soc_pkg::DATA_W;
	localparam int GW = soc_pkg::GPIO_W_DEFAULT;
	localparam int BUS_TIMEOUT = 20;
	localparam int IRQ_TIMEOUT = 200;

	// Timer control values
	localparam logic [31:0] CTRL_EN    = 32'd1 << soc_pkg::TCTRL_EN;
	localparam logic [31:0] CTRL_AR    = 32'd1 << soc_pkg::TCTRL_AR;
	localparam logic [31:0] CTRL_IRQEN = 32'd1 << soc_pkg::TCTRL_IRQEN;
	localparam logic [31:0] CTRL_TRIG  = 32'd1 << soc_pkg::TCTRL_TRIG;

	logic                       clk;
	logic                       reset_i;
	logic                       cyc_i;
	logic                       stb_i;
	logic                       we_i;
	logic [soc_pkg::ADDR_W-1:0] adr_i;
	logic [DW-1:0]              dat_i;
	logic [DW-1:0]              dat_o;
	logic                       ack_o;
	logic [GW-1:0]              gpio_in_i;
	logic [GW-1:0]              gpio_out_o;
	logic [2:0]                 irq_n_o;

	logic [31:0] lfsr;

	//----------------------------------------------------------------------
	// Register model
	//----------------------------------------------------------------------
	logic [GW-1:0] m_out;
	logic [GW-1:0] m_mask;
	logic [GW-1:0] m_in;
	logic [DW-1:0] m_cmp0;
	logic [DW-1:0] m_cmp1;
	logic          m_irq_gpio;
	logic          m_irq_t0;
	logic          m_irq_t1;

	soc_periph_top soc_periph_top_inst (
		.clk        (clk),
		.reset_i    (reset_i),
		.cyc_i      (cyc_i),
		.stb_i      (stb_i),
		.we_i       (we_i),
		.adr_i      (adr_i),
		.dat_i      (dat_i),
		.dat_o      (dat_o),
		.ack_o      (ack_o),
		.gpio_in_i  (gpio_in_i),
		.gpio_out_o (gpio_out_o),
		.irq_n_o    (irq_n_o)
	);

	// 20 ns period
	always #10 clk = ~clk;

	// Right-shifting Galois LFSR
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = s >> 1;
		if (s[0])
			lfsr_step = lfsr_step ^ 32'hD000_0001;
	endfunction

	// One step per bit taken
	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// Region in bits 31..17, word index in bits 4..2
	function automatic logic [31:0] reg_addr(input logic [14:0] region, input logic [2:0] idx);
		reg_addr = {region, 12'h000, idx, 2'b00};
	endfunction

	// Active-low vector with bit 0 timer 0, bit 1 GPIO and bit 2 timer 1
	function automatic logic [2:0] irq_vector();
		irq_vector = ~{m_irq_t1, m_irq_gpio, m_irq_t0};
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input logic [DW-1:0] exp,
		input logic [DW-1:0] act);
		if (act !== exp)
			report_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_irq(input string name, input logic [2:0] exp, input logic [2:0] act);
		if (act !== exp)
			report_failure($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
	endtask

	task automatic check_leds(input string name, input logic [GW-1:0] exp,
		input logic [GW-1:0] act);
		if (act !== exp)
			report_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
	endtask

	//----------------------------------------------------------------------
	// Bus master
	//----------------------------------------------------------------------
	// Ack seen at the falling edge holds through the next rising edge
	task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int   n;
		logic seen;
		@(negedge clk);
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i = we;
		adr_i = adr;
		dat_i = wdat;
		seen = 1'b0;
		rdat = '0;
		for (n = 0; n < BUS_TIMEOUT && !seen; n++) begin
			@(negedge clk);
			if (ack_o) begin
				seen = 1'b1;
				rdat = dat_o;
			end
		end
		if (!seen)
			report_failure($sformatf("Bus timeout, no ack for address %h", adr));
		if (n != 1)
			report_failure($sformatf("Ack for address %h came %0d cycles late", adr, n - 1));
		@(negedge clk);
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i = 1'b0;
	endtask

	task automatic write_reg(input logic [31:0] adr, input logic [31:0] wdat);
		logic [31:0] unused;
		bus_cycle(1'b1, adr, wdat, unused);
	endtask

	task automatic read_reg(input logic [31:0] adr, output logic [31:0] rdat);
		bus_cycle(1'b0, adr, 32'h0, rdat);
	endtask

	task automatic wait_irq_low(input int bit_idx, input string name);
		logic seen;
		seen = 1'b0;
		for (int n = 0; n < IRQ_TIMEOUT && !seen; n++) begin
			@(negedge clk);
			seen = !irq_n_o[bit_idx];
		end
		if (!seen)
			report_failure($sformatf("Timeout waiting for the %s interrupt", name));
	endtask

	//----------------------------------------------------------------------
	// Test sequence
	//----------------------------------------------------------------------
	initial begin
		logic [31:0] rd;
		logic [31:0] v;
		logic [31:0] adr;
		clk = 1'b0;
		reset_i = 1'b1;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i = 1'b0;
		adr_i = '0;
		dat_i = '0;
		gpio_in_i = '0;
		lfsr = 32'd20;
		m_out = '0;
		m_mask = '0;
		m_in = '0;
		m_cmp0 = '0;
		m_cmp1 = '0;
		m_irq_gpio = 1'b0;
		m_irq_t0 = 1'b0;
		m_irq_t1 = 1'b0;
		repeat (5) @(negedge clk);
		reset_i = 1'b0;

		// State after reset
		@(negedge clk);
		if (ack_o !== 1'b0)
			report_failure("ack_o is not low after reset");
		check_irq("reset irq_n", irq_vector(), irq_n_o);
		check_leds("reset gpio_out", m_out, gpio_out_o);
		read_reg(reg_addr(soc_pkg::TIMER_REGION, soc_pkg::T0_CTRL), rd);
		check_data("reset T0_CTRL", 32'h0, rd);
		read_reg(reg_addr(soc_pkg::TIMER_REGION, soc_pkg::T1_COUNTER), rd);
		check_data("reset T1_COUNTER", 32'h0, rd);

		// GPIO output read-back
		for (int i = 0; i < 8; i++) begin
			rand_bits(32, v);
			write_reg(reg_addr(soc_pkg::GPIO_REGION, soc_pkg::GPIO_OUT), v);
			m_out = v[GW-1:0];
			check_leds("gpio_out pins", m_out, gpio_out_o);
			read_reg(reg_addr(soc_pkg::GPIO_REGION, soc_pkg::GPIO_OUT), rd);
			check_data("gpio_out read", DW'(m_out), rd);
		end

		// GPIO input and masked interrupt
		for (int i = 0; i < 8; i++) begin
			rand_bits(GW, v);
			@(negedge clk);
			gpio_in_i = v[GW-1:0];
			m_in = v[GW-1:0];
			read_reg(reg_addr(soc_pkg::GPIO_REGION, soc_pkg::GPIO_IN), rd);
			check_data("gpio_in read", DW'(m_in), rd);
			rand_bits(GW, v);
			m_mask = v[GW-1:0];
			write_reg(reg_addr(soc_pkg::GPIO_REGION, soc_pkg::GPIO_MASK), v);
			m_irq_gpio = |(m_in & m_mask);
			read_reg(reg_addr(soc_pkg::GPIO_REGION, soc_pkg::GPIO_MASK), rd);
			check_data("gpio_mask read", DW'(m_mask), rd);
			check_irq("gpio irq_n", irq_vector(), irq_n_o);
		end
		// Quiet GPIO during the timer tests
		write_reg(reg_addr(soc_pkg::GPIO_REGION, soc_pkg::GPIO_MASK), 32'h0);
		m_mask = '0;
		m_irq_gpio = 1'b0;
		check_irq("gpio irq_n masked", irq_vector(), irq_n_o);

		// One-shot timer 0
		for (int i = 0; i < 3; i++) begin
			rand_bits(4, v);
			m_cmp0 = v + 32'd2;
			write_reg(reg_addr(soc_pkg::TIMER_REGION, soc_pkg::T0_COMPARE), m_cmp0);
			write_reg(reg_addr(soc_pkg::TIMER_REGION, soc_pkg::T0_CTRL), CTRL_EN | CTRL_IRQEN);
			wait_irq_low(0, "timer 0 one-shot");
			m_irq_t0 = 1'b1;
			check_irq("timer 0 irq_n", irq_vector(), irq_n_o);
			read_reg(reg_addr(soc_pkg::TIMER_REGION, soc_pkg::T0_CTRL), rd);
			check_data("T0_CTRL after trigger", CTRL_TRIG | CTRL_IRQEN, rd);
			read_reg(reg_addr(soc_pkg::TIMER_REGION, soc_pkg::T0_COUNTER), rd);
			check_data("T0_COUNTER after trigger", 32'h0, rd);
			write_reg(reg_addr(soc_pkg::TIMER_REGION, soc_pkg::T0_CTRL), 32'h0);
			m_irq_t0 = 1'b0;
			check_irq("timer 0 irq_n cleared", irq_vector(), irq_n_o);
		end

		// Auto-reload timer 1 with compare kept well above the clear latency
		rand_bits(4, v);
		m_cmp1 = v + 32'd8;
		write_reg(reg_addr(soc_pkg::TIMER_REGION, soc_pkg::T1_COMPARE), m_cmp1);
		write_reg(reg_addr(soc_pkg::TIMER_REGION, soc_pkg::T1_CTRL),
			CTRL_EN | CTRL_AR | CTRL_IRQEN);
		wait_irq_low(2, "timer 1 first");
		m_irq_t1 = 1'b1;
		check_irq("timer 1 irq_n", irq_vector(), irq_n_o);
		write_reg(reg_addr(soc_pkg::TIMER_REGION, soc_pkg::T1_CTRL),
			CTRL_EN | CTRL_AR | CTRL_IRQEN);
		m_irq_t1 = 1'b0;
		check_irq("timer 1 irq_n trig cleared", irq_vector(), irq_n_o);
		wait_irq_low(2, "timer 1 reload");
		m_irq_t1 = 1'b1;
		read_reg(reg_addr(soc_pkg::TIMER_REGION, soc_pkg::T1_CTRL), rd);
		check_data("T1_CTRL after reload", CTRL_EN | CTRL_AR | CTRL_IRQEN | CTRL_TRIG, rd);
		write_reg(reg_addr(soc_pkg::TIMER_REGION, soc_pkg::T1_CTRL), 32'h0);
		m_irq_t1 = 1'b0;
		check_irq("timer 1 irq_n stopped", irq_vector(), irq_n_o);

		// Unmapped reads and writes
		for (int i = 0; i < 4; i++) begin
			rand_bits(32, adr);
			if (adr[31:17] == soc_pkg::TIMER_REGION || adr[31:17] == soc_pkg::GPIO_REGION)
				adr = adr ^ 32'h8000_0000;
			read_reg(adr, rd);
			check_data("unmapped read", 32'h0, rd);
			rand_bits(32, v);
			write_reg(adr, v);
		end
		read_reg(reg_addr(soc_pkg::GPIO_REGION, soc_pkg::GPIO_OUT), rd);
		check_data("gpio_out after unmapped", DW'(m_out), rd);
		read_reg(reg_addr(soc_pkg::GPIO_REGION, soc_pkg::GPIO_MASK), rd);
		check_data("gpio_mask after unmapped", DW'(m_mask), rd);
		read_reg(reg_addr(soc_pkg::TIMER_REGION, soc_pkg::T0_COMPARE), rd);
		check_data("T0_COMPARE after unmapped", m_cmp0, rd);
		read_reg(reg_addr(soc_pkg::TIMER_REGION, soc_pkg::T1_COMPARE), rd);
		check_data("T1_COMPARE after unmapped", m_cmp1, rd);

		// Compare register read-back
		rand_bits(32, m_cmp0);
		write_reg(reg_addr(soc_pkg::TIMER_REGION, soc_pkg::T0_COMPARE), m_cmp0);
		rand_bits(32, m_cmp1);
		write_reg(reg_addr(soc_pkg::TIMER_REGION, soc_pkg::T1_COMPARE), m_cmp1);
		read_reg(reg_addr(soc_pkg::TIMER_REGION, soc_pkg::T0_COMPARE), rd);
		check_data("T0_COMPARE read", m_cmp0, rd);
		read_reg(reg_addr(soc_pkg::TIMER_REGION, soc_pkg::T1_COMPARE), rd);
		check_data("T1_COMPARE read", m_cmp1, rd);

		$display("Done: no errors");
		$finish;
	end

endmodule

/* all.f */
rtl/soc_pkg.sv
rtl/wb_gpio.sv
rtl/wb_timer.sv
rtl/wb_periph_decode.sv
rtl/soc_periph_top.sv
sim/soc_periph_properties.sv
sim/soc_periph_tb.sv

/* Makefile */
# Verilator lint, simulation and clean for the peripheral slice

TOP := soc_periph_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f all.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Done: errors found" sim.log || ! grep -q "Done: no errors" sim.log; then \
		echo "Simulation FAILED"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir sim.log
